// File: acc_macros.svh
// Word width, pipeline depth, tag and FIFO size defines for the accumulator
`ifndef ACC_MACROS_SVH
`define ACC_MACROS_SVH

// Data and accumulator word
`define ACC_WIDTH 32

// MAC pipeline depth, which also bounds the sums in flight
`define ACC_NUM_REGS 4
`define ACC_TAG_W $clog2(`ACC_NUM_REGS)
`define ACC_USES_W ($clog2(`ACC_NUM_REGS) + 1)

`define ACC_FACT_DEPTH 4
`define ACC_ADD_DEPTH (`ACC_NUM_REGS * `ACC_FACT_DEPTH)

`endif

// File: src/acc_pkg.sv
// Opcode and state enums, queue entry structs, flag and control structs
`include "acc_macros.svh"

package acc_pkg;

    typedef enum logic [1:0] {
        ACC_OP_ADD,
        ACC_OP_MUL,
        ACC_OP_FMADD
    } acc_op_e;

    typedef enum logic [1:0] {
        ST_ACCUM,
        ST_DRAIN,
        ST_REDUCE,
        ST_DONE
    } acc_state_e;

    typedef struct packed {
        logic [`ACC_WIDTH-1:0] value;
        logic [`ACC_TAG_W-1:0] tag;
    } addend_t;

    // Uses is the number of partial sums this factor still has to scale
    typedef struct packed {
        logic [`ACC_WIDTH-1:0]  value;
        logic [`ACC_TAG_W-1:0]  tag;
        logic [`ACC_USES_W-1:0] uses;
    } factor_t;

    typedef struct packed {
        logic addend_empty;
        logic factor_empty;
        logic busy;
        logic last_op_in_flight;
    } acc_flags_t;

    typedef struct packed {
        logic reducing;
        logic flush;
        logic capture;
    } acc_ctrl_t;

endpackage

// File: src/acc_tag_fifo.sv
// Flushable circular-buffer FIFO with a generic entry type
`timescale 1ns/1ps

module acc_tag_fifo #(
    parameter type         entry_t = logic,
    parameter int unsigned DEPTH   = 4
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   flush_i,
    input  logic   push_i,
    input  entry_t data_i,
    input  logic   pop_i,
    output entry_t data_o,
    output logic   full_o,
    output logic   empty_o
);

    localparam int unsigned      PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);

    entry_t           mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == FULL_CNT);
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: src/acc_operand_queue.sv
// Addend and factor queues, tag counter, factor use counter and tag matching
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_operand_queue
    import acc_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  acc_ctrl_t              ctrl_i,
    input  logic                   accept_i,
    input  logic                   add_valid_i,
    input  logic [`ACC_WIDTH-1:0]  add_i,
    input  logic                   mul_valid_i,
    input  logic [`ACC_WIDTH-1:0]  mul_i,
    output logic                   ready_o,
    input  logic                   fb_valid_i,
    input  logic [`ACC_TAG_W-1:0]  fb_tag_i,
    input  logic [`ACC_WIDTH-1:0]  fb_data_i,
    input  logic                   push_res_i,
    input  logic [`ACC_USES_W-1:0] inflight_i,
    input  logic                   addend_pop_i,
    output addend_t                addend_o,
    output factor_t                factor_o,
    output logic                   addend_empty_o,
    output logic                   factor_empty_o,
    output logic                   addend_match_o,
    output logic                   factor_match_o
);

    logic [`ACC_TAG_W-1:0]  tag_cnt_q;
    logic [`ACC_USES_W-1:0] uses_cnt_q;
    addend_t                addend_in;
    factor_t                factor_in;
    logic                   addend_push;
    logic                   addend_full;
    logic                   factor_push;
    logic                   factor_pop;
    logic                   factor_full;
    logic                   new_sum;
    logic                   last_use;

    assign ready_o     = accept_i & ~addend_full & ~factor_full;
    assign factor_push = mul_valid_i & ready_o;
    assign addend_push = (add_valid_i & ready_o) | push_res_i;

    // An addend taken with a factor in the same cycle escapes that factor
    assign addend_in.value = push_res_i ? fb_data_i : add_i;
    assign addend_in.tag   = push_res_i  ? fb_tag_i :
                             factor_push ? tag_cnt_q + 1'b1 : tag_cnt_q;

    // A sum started in this cycle also needs the new factor
    assign new_sum         = addend_pop_i & ~fb_valid_i;
    assign factor_in.value = mul_i;
    assign factor_in.tag   = tag_cnt_q;
    assign factor_in.uses  = new_sum ? inflight_i + 1'b1 : inflight_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_cnt_q <= '0;
        end else if (ctrl_i.flush) begin
            tag_cnt_q <= '0;
        end else if (factor_push) begin
            tag_cnt_q <= tag_cnt_q + 1'b1;
        end
    end

    // Same-level addends are folded in before the factor moves a sum on
    assign factor_match_o = fb_valid_i & ~factor_empty_o & (factor_o.tag == fb_tag_i)
                          & ((factor_o.tag != addend_o.tag) | addend_empty_o);
    assign addend_match_o = fb_valid_i & ~addend_empty_o
                          & (addend_o.tag == (factor_match_o ? fb_tag_i + 1'b1 : fb_tag_i));

    // A factor that found nothing in flight is dropped straight away
    assign last_use   = (uses_cnt_q == factor_o.uses - 1'b1);
    assign factor_pop = (factor_match_o & last_use) | (~factor_empty_o & (factor_o.uses == '0));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            uses_cnt_q <= '0;
        end else if (ctrl_i.flush) begin
            uses_cnt_q <= '0;
        end else if (factor_match_o) begin
            uses_cnt_q <= last_use ? '0 : uses_cnt_q + 1'b1;
        end
    end

    acc_tag_fifo #(
        .entry_t (addend_t),
        .DEPTH   (`ACC_ADD_DEPTH)
    ) i_addend_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (ctrl_i.flush),
        .push_i  (addend_push),
        .data_i  (addend_in),
        .pop_i   (addend_pop_i),
        .data_o  (addend_o),
        .full_o  (addend_full),
        .empty_o (addend_empty_o)
    );

    acc_tag_fifo #(
        .entry_t (factor_t),
        .DEPTH   (`ACC_FACT_DEPTH)
    ) i_factor_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (ctrl_i.flush),
        .push_i  (factor_push),
        .data_i  (factor_in),
        .pop_i   (factor_pop),
        .data_o  (factor_o),
        .full_o  (factor_full),
        .empty_o (factor_empty_o)
    );

endmodule

// File: src/acc_issue_ctrl.sv
// MAC issue logic, in-flight sum counter, reduction pairing and result register
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_issue_ctrl
    import acc_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  acc_ctrl_t              ctrl_i,
    input  addend_t                addend_i,
    input  factor_t                factor_i,
    input  logic                   addend_empty_i,
    input  logic                   factor_empty_i,
    input  logic                   addend_match_i,
    input  logic                   factor_match_i,
    input  logic                   res_valid_i,
    input  logic [`ACC_TAG_W-1:0]  res_tag_i,
    input  logic [`ACC_WIDTH-1:0]  res_i,
    output logic                   addend_pop_o,
    output logic                   push_res_o,
    output logic [`ACC_USES_W-1:0] inflight_o,
    output logic                   issue_valid_o,
    output acc_op_e                op_o,
    output logic [`ACC_WIDTH-1:0]  opa_o,
    output logic [`ACC_WIDTH-1:0]  opb_o,
    output logic [`ACC_WIDTH-1:0]  opc_o,
    output logic [`ACC_TAG_W-1:0]  tag_o,
    output acc_flags_t             flags_o,
    output logic [`ACC_WIDTH-1:0]  acc_o
);

    localparam logic [`ACC_USES_W-1:0] MAX_INFLIGHT = `ACC_NUM_REGS;

    logic [`ACC_USES_W-1:0] inflight_q;
    logic [`ACC_WIDTH-1:0]  acc_q;
    logic                   start_new;
    logic                   recirc;
    logic                   combine;

    // A free MAC slot opens a new partial sum from the addend head
    assign start_new = ~ctrl_i.reducing & ~res_valid_i & ~addend_empty_i
                     & (inflight_q != MAX_INFLIGHT);
    assign recirc    = ~ctrl_i.reducing & res_valid_i;

    // In reduction a result pairs with the one waiting, or waits itself
    assign combine    = ctrl_i.reducing & res_valid_i & ~addend_empty_i;
    assign push_res_o = ctrl_i.reducing & res_valid_i & addend_empty_i;

    assign issue_valid_o = start_new | recirc | combine;
    assign addend_pop_o  = start_new | combine | (recirc & addend_match_i);

    always_comb begin
        op_o  = ACC_OP_ADD;
        tag_o = res_valid_i ? res_tag_i : addend_i.tag;
        if (factor_match_i) begin
            op_o  = addend_match_i ? ACC_OP_FMADD : ACC_OP_MUL;
            tag_o = res_tag_i + 1'b1;
        end
    end

    assign opa_o = factor_i.value;
    assign opb_o = res_valid_i ? res_i : addend_i.value;
    assign opc_o = (res_valid_i & (addend_match_i | ctrl_i.reducing)) ? addend_i.value : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inflight_q <= '0;
        end else if (ctrl_i.flush) begin
            inflight_q <= '0;
        end else if (combine) begin
            inflight_q <= inflight_q - 1'b1;
        end else if (start_new) begin
            inflight_q <= inflight_q + 1'b1;
        end
    end

    // The final sum sits at the addend head when it is captured
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            acc_q <= '0;
        end else if (ctrl_i.capture) begin
            acc_q <= addend_empty_i ? '0 : addend_i.value;
        end
    end

    assign inflight_o = inflight_q;
    assign acc_o      = acc_q;

    assign flags_o.addend_empty      = addend_empty_i;
    assign flags_o.factor_empty      = factor_empty_i;
    assign flags_o.busy              = (inflight_q != '0);
    assign flags_o.last_op_in_flight = (inflight_q == 1);

endmodule

// File: src/acc_mac_pipe.sv
// Non-stalling integer multiply-add pipeline carrying tag and valid
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_mac_pipe
    import acc_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  valid_i,
    input  acc_op_e               op_i,
    input  logic [`ACC_WIDTH-1:0] a_i,
    input  logic [`ACC_WIDTH-1:0] b_i,
    input  logic [`ACC_WIDTH-1:0] c_i,
    input  logic [`ACC_TAG_W-1:0] tag_i,
    output logic                  valid_o,
    output logic [`ACC_TAG_W-1:0] tag_o,
    output logic [`ACC_WIDTH-1:0] res_o
);

    localparam int unsigned N = `ACC_NUM_REGS;

    logic [`ACC_WIDTH-1:0] prod_d;
    logic [`ACC_WIDTH-1:0] addend_d;
    logic [`ACC_WIDTH-1:0] prod_q;
    logic [`ACC_WIDTH-1:0] addend_q;
    logic [`ACC_WIDTH-1:0] data_q [1:N-1];
    logic [`ACC_TAG_W-1:0] tag_q [N];
    logic [N-1:0]          valid_q;

    // Stage 0 forms the product, stage 1 adds, later stages only delay
    always_comb begin
        prod_d   = a_i * b_i;
        addend_d = c_i;
        if (op_i == ACC_OP_ADD) begin
            prod_d = b_i;
        end
        if (op_i == ACC_OP_MUL) begin
            addend_d = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        prod_q    <= prod_d;
        addend_q  <= addend_d;
        tag_q[0]  <= tag_i;
        data_q[1] <= prod_q + addend_q;
        tag_q[1]  <= tag_q[0];
        for (int i = 2; i < N; i++) begin
            data_q[i] <= data_q[i-1];
            tag_q[i]  <= tag_q[i-1];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[N-2:0], valid_i};
        end
    end

    assign valid_o = valid_q[N-1];
    assign tag_o   = tag_q[N-1];
    assign res_o   = data_q[N-1];

endmodule

// File: src/acc_controller.sv
// Accumulate, drain, reduce and done FSM for the accumulator datapath
`timescale 1ns/1ps

module acc_controller
    import acc_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       clear_i,
    input  logic       finish_i,
    input  acc_flags_t flags_i,
    input  logic       res_valid_i,
    output acc_ctrl_t  ctrl_o,
    output logic       valid_o,
    output logic       accept_o
);

    acc_state_e state_q;
    acc_state_e state_d;
    logic       valid_q;
    logic       last_out;

    // Only one sum is left and it is leaving the MAC with no partner waiting
    assign last_out = flags_i.last_op_in_flight & res_valid_i & flags_i.addend_empty;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_ACCUM: begin
                if (finish_i) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (flags_i.addend_empty && flags_i.factor_empty) begin
                    state_d = ST_REDUCE;
                end
            end
            ST_REDUCE: begin
                if (last_out || !flags_i.busy) begin
                    state_d = ST_DONE;
                end
            end
            default: state_d = ST_ACCUM;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_ACCUM;
            valid_q <= 1'b0;
        end else if (clear_i) begin
            state_q <= ST_ACCUM;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Pulse lines up with the freshly loaded result
            valid_q <= (state_q == ST_DONE);
        end
    end

    assign ctrl_o.reducing = (state_q == ST_REDUCE);
    assign ctrl_o.capture  = (state_q == ST_DONE);
    assign ctrl_o.flush    = clear_i | (state_q == ST_DONE);

    assign accept_o = (state_q == ST_ACCUM) & ~clear_i;
    assign valid_o  = valid_q;

endmodule

// File: src/acc_datapath_top.sv
// Accumulator datapath top with queue, issue logic, MAC pipeline and controller
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_datapath_top
    import acc_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  clear_i,
    input  logic                  add_valid_i,
    input  logic [`ACC_WIDTH-1:0] add_i,
    input  logic                  mul_valid_i,
    input  logic [`ACC_WIDTH-1:0] mul_i,
    input  logic                  finish_i,
    output logic                  ready_o,
    output logic                  valid_o,
    output logic [`ACC_WIDTH-1:0] acc_o,
    output acc_flags_t            flags_o
);

    acc_ctrl_t              ctrl;
    logic                   accept;
    addend_t                addend;
    factor_t                factor;
    logic                   addend_empty;
    logic                   factor_empty;
    logic                   addend_match;
    logic                   factor_match;
    logic                   addend_pop;
    logic                   push_res;
    logic [`ACC_USES_W-1:0] inflight;
    logic                   issue_valid;
    acc_op_e                op;
    logic [`ACC_WIDTH-1:0]  opa;
    logic [`ACC_WIDTH-1:0]  opb;
    logic [`ACC_WIDTH-1:0]  opc;
    logic [`ACC_TAG_W-1:0]  issue_tag;
    logic                   res_valid;
    logic [`ACC_TAG_W-1:0]  res_tag;
    logic [`ACC_WIDTH-1:0]  res;

    acc_operand_queue i_operand_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ctrl_i         (ctrl),
        .accept_i       (accept),
        .add_valid_i    (add_valid_i),
        .add_i          (add_i),
        .mul_valid_i    (mul_valid_i),
        .mul_i          (mul_i),
        .ready_o        (ready_o),
        .fb_valid_i     (res_valid),
        .fb_tag_i       (res_tag),
        .fb_data_i      (res),
        .push_res_i     (push_res),
        .inflight_i     (inflight),
        .addend_pop_i   (addend_pop),
        .addend_o       (addend),
        .factor_o       (factor),
        .addend_empty_o (addend_empty),
        .factor_empty_o (factor_empty),
        .addend_match_o (addend_match),
        .factor_match_o (factor_match)
    );

    acc_issue_ctrl i_issue_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ctrl_i         (ctrl),
        .addend_i       (addend),
        .factor_i       (factor),
        .addend_empty_i (addend_empty),
        .factor_empty_i (factor_empty),
        .addend_match_i (addend_match),
        .factor_match_i (factor_match),
        .res_valid_i    (res_valid),
        .res_tag_i      (res_tag),
        .res_i          (res),
        .addend_pop_o   (addend_pop),
        .push_res_o     (push_res),
        .inflight_o     (inflight),
        .issue_valid_o  (issue_valid),
        .op_o           (op),
        .opa_o          (opa),
        .opb_o          (opb),
        .opc_o          (opc),
        .tag_o          (issue_tag),
        .flags_o        (flags_o),
        .acc_o          (acc_o)
    );

    acc_mac_pipe i_mac_pipe (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (ctrl.flush),
        .valid_i (issue_valid),
        .op_i    (op),
        .a_i     (opa),
        .b_i     (opb),
        .c_i     (opc),
        .tag_i   (issue_tag),
        .valid_o (res_valid),
        .tag_o   (res_tag),
        .res_o   (res)
    );

    acc_controller i_controller (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .finish_i    (finish_i),
        .flags_i     (flags_o),
        .res_valid_i (res_valid),
        .ctrl_o      (ctrl),
        .valid_o     (valid_o),
        .accept_o    (accept)
    );

endmodule

// File: dv/acc_clk_gen.sv
// Testbench clock and power-on reset source
`timescale 1ns/1ps

module acc_clk_gen #(
    parameter int unsigned HALF_PERIOD  = 10,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release lands just after an edge, clear of the flops
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_no = 1'b1;
    end

endmodule

// File: dv/acc_tb.sv
// Vector-driven testbench for the accumulator datapath with checks and result report
`timescale 1ns/1ps
`include "acc_macros.svh"

module acc_tb
    import acc_pkg::*;
();

    localparam int W       = `ACC_WIDTH;
    localparam int TIMEOUT = 500;

    logic             clk;
    logic             rst_n;
    logic             clear;
    logic             add_valid;
    logic [W-1:0]     add_data;
    logic             mul_valid;
    logic [W-1:0]     mul_data;
    logic             finish;
    logic             ready;
    logic             valid;
    logic [W-1:0]     acc;
    acc_flags_t       flags;

    integer           fd;
    integer           seed;
    integer           code;
    int               pass_count;
    int               fail_count;
    int               err_count;
    logic             timed_out;
    logic             burst;
    logic             saw_low;
    logic [7:0]       tok;
    logic [8*32-1:0]  name;
    logic [8*128-1:0] line;
    logic [W-1:0]     val_a;
    logic [W-1:0]     val_m;
    logic [W-1:0]     expected;

    acc_clk_gen i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    acc_datapath_top i_acc_datapath_top (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .clear_i     (clear),
        .add_valid_i (add_valid),
        .add_i       (add_data),
        .mul_valid_i (mul_valid),
        .mul_i       (mul_data),
        .finish_i    (finish),
        .ready_o     (ready),
        .valid_o     (valid),
        .acc_o       (acc),
        .flags_o     (flags)
    );

    task automatic check_value(input logic [W-1:0] exp_val, input logic [W-1:0] act_val);
        if (exp_val !== act_val) begin
            $display("mismatch: test %0s expected %h actual %h", name, exp_val, act_val);
            err_count++;
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            $display("Test %0s has a malformed line in the vector file", name);
            fail_count++;
        end
    endtask

    task automatic report_test();
        if (err_count == 0) begin
            pass_count++;
            $display("Test %0s passed", name);
        end else begin
            fail_count++;
            $display("Test %0s failed with %0d errors", name, err_count);
        end
    endtask

    // Hold the strobes until the DUT takes them at a rising edge
    task automatic apply_op(input logic do_add, input logic do_mul,
                            input logic [W-1:0] a, input logic [W-1:0] m);
        int waited;
        waited    = 0;
        add_valid = do_add;
        mul_valid = do_mul;
        add_data  = a;
        mul_data  = m;
        @(negedge clk);
        while (!ready && waited < TIMEOUT) begin
            saw_low = 1'b1;
            waited++;
            @(negedge clk);
        end
        if (!ready) begin
            $display("Test %0s timed out waiting for ready_o", name);
            timed_out = 1'b1;
            fail_count++;
        end
        @(posedge clk);
        #2;
        add_valid = 1'b0;
        mul_valid = 1'b0;
    endtask

    task automatic idle_gap();
        int gap;
        gap = burst ? 0 : ($random(seed) & 3);
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
    endtask

    // End of stream, then wait for the result pulse
    task automatic finish_and_check();
        int waited;
        waited = 0;
        finish = 1'b1;
        @(posedge clk);
        #2;
        finish = 1'b0;
        @(negedge clk);
        while (!valid && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!valid) begin
            $display("Test %0s timed out waiting for valid_o", name);
            timed_out = 1'b1;
            err_count++;
        end else begin
            check_value(expected, acc);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        seed       = 32'h92ef_988b;
        pass_count = 0;
        fail_count = 0;
        err_count  = 0;
        timed_out  = 1'b0;
        burst      = 1'b0;
        saw_low    = 1'b0;
        name       = '0;
        expected   = '0;
        clear      = 1'b0;
        add_valid  = 1'b0;
        add_data   = '0;
        mul_valid  = 1'b0;
        mul_data   = '0;
        finish     = 1'b0;

        fd = $fopen("dv/acc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/acc_vectors.txt");
            fail_count++;
        end

        repeat (11) @(posedge clk);
        #2;

        while (fd != 0 && !timed_out && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "T") begin
                code      = $fscanf(fd, "%s", name);
                err_count = 0;
                burst     = 1'b0;
                saw_low   = 1'b0;
                expect_fields(code, 1);
            end else if (tok == "P") begin
                burst = 1'b1;
            end else if (tok == "R") begin
                @(negedge clk);
                check_value('0, W'(valid));
                check_value(W'(1), W'(ready));
                check_value(W'(1), W'(flags.addend_empty));
                check_value(W'(1), W'(flags.factor_empty));
                check_value('0, W'(flags.busy));
                check_value('0, W'(flags.last_op_in_flight));
                check_value('0, acc);
                report_test();
                @(posedge clk);
                #2;
            end else if (tok == "A") begin
                code = $fscanf(fd, "%h", val_a);
                expect_fields(code, 1);
                apply_op(1'b1, 1'b0, val_a, '0);
                idle_gap();
            end else if (tok == "M") begin
                code = $fscanf(fd, "%h", val_m);
                expect_fields(code, 1);
                apply_op(1'b0, 1'b1, '0, val_m);
                idle_gap();
            end else if (tok == "B") begin
                code = $fscanf(fd, "%h %h", val_a, val_m);
                expect_fields(code, 2);
                apply_op(1'b1, 1'b1, val_a, val_m);
                idle_gap();
            end else if (tok == "C") begin
                clear = 1'b1;
                @(posedge clk);
                #2;
                clear = 1'b0;
                // The result register keeps the last result across a clear
                check_value(expected, acc);
            end else if (tok == "E") begin
                code = $fscanf(fd, "%h", expected);
                expect_fields(code, 1);
                finish_and_check();
                if (burst) begin
                    check_value(W'(1), W'(saw_low));
                end
                report_test();
            end else begin
                $display("Unknown token %0s in the vector file", tok);
                fail_count++;
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/acc_vectors.txt
# Tokens: T name starts a test, R checks the idle state after reset, E hex ends it
# A hex is an addend, M hex a factor, B hex hex both in one cycle, C a clear pulse
# P turns off the idle gaps and expects ready_o to drop
T reset R
T plain_sum
A 00000011 A fffffff0 A 00000022 A 00000100
E 00000123
T scaling
A 00000003 M 00000002 A 00000005 M 00000003 A 00000007
E 00000028
T scale_wrap
A 00010000 M 00010000 A 00000003 M 00000005
E 0000000f
T same_cycle
A 00000004 B 00000006 00000003 A 00000001
E 00000013
T backpressure P
A 00000001 A 00000002 A 00000003 A 00000004
M 00000002 M 00000002 M 00000002 M 00000002 M 00000002 M 00000002
E 00000280
T clear
A 00000009 M 00000005 A 00000007 C A 00000002 M 00000003 A 00000001
E 00000007

// File: project.f
+incdir+.
src/acc_pkg.sv
src/acc_tag_fifo.sv
src/acc_operand_queue.sv
src/acc_issue_ctrl.sv
src/acc_mac_pipe.sv
src/acc_controller.sv
src/acc_datapath_top.sv
dv/acc_clk_gen.sv
dv/acc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= acc_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := acc_macros.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
